// ==== bench/row_mem_loader_props.sv ====
module row_mem_loader_props #(
    parameter int num_act_banks = row_mem_pkg::def_num_act_banks,
    parameter int num_weight_banks = row_mem_pkg::def_num_weight_banks
) (
    input logic                          clk,
    input logic                          resetn,
    input logic                          done,
    input logic [num_act_banks-1:0]      act_bank_en,
    input logic [num_act_banks-1:0]      act_bank_we,
    input logic [num_weight_banks-1:0]   weight_bank_en,
    input logic [num_weight_banks-1:0]   weight_bank_we
);

    timeunit 1ns;
    timeprecision 100ps;

    // --------------------
    // done pulse
    // --------------------

    done_single: assert property (@(posedge clk) disable iff (!resetn) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // nothing written in the cycle after done
    quiet_after_done: assert property (@(posedge clk) disable iff (!resetn)
        done |=> (act_bank_en == '0 && weight_bank_en == '0))
        else $error("bank enable set in the cycle after done");

    // --------------------
    // enable vectors
    // --------------------

    act_onehot: assert property (@(posedge clk) disable iff (!resetn) $onehot0(act_bank_en))
        else $error("activation enable has more than one bank set");

    weight_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(weight_bank_en))
        else $error("weight enable has more than one bank set");

    act_en_we: assert property (@(posedge clk) disable iff (!resetn)
        act_bank_en == act_bank_we)
        else $error("activation enable and write enable differ");

    weight_en_we: assert property (@(posedge clk) disable iff (!resetn)
        weight_bank_en == weight_bank_we)
        else $error("weight enable and write enable differ");

endmodule

bind row_mem_loader row_mem_loader_props #(
    .num_act_banks(num_act_banks),
    .num_weight_banks(num_weight_banks)
) i_props (
    .clk(clk),
    .resetn(resetn),
    .done(done),
    .act_bank_en(act_bank_en),
    .act_bank_we(act_bank_we),
    .weight_bank_en(weight_bank_en),
    .weight_bank_we(weight_bank_we)
);

// ==== bench/row_mem_loader_tb.sv ====
module row_mem_loader_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int data_width = row_mem_pkg::def_data_width;
    localparam int num_act_banks = row_mem_pkg::def_num_act_banks;
    localparam int num_weight_banks = row_mem_pkg::def_num_weight_banks;
    localparam int act_addr_width = row_mem_pkg::def_act_addr_width;
    localparam int weight_addr_width = row_mem_pkg::def_weight_addr_width;
    localparam int bank_addr_width = row_mem_pkg::def_bank_addr_width;
    localparam int num_layers = 8;

    logic clk;
    logic resetn;
    logic start;
    logic done;
    logic [layer_geom_pkg::oc_width-1:0] oc;
    logic [layer_geom_pkg::img_width-1:0] img_h;
    logic [layer_geom_pkg::img_width-1:0] img_w;
    logic [layer_geom_pkg::k_width-1:0] k;
    logic [layer_geom_pkg::stride_width-1:0] stride;
    logic signed [data_width-1:0] act_data;
    logic [act_addr_width-1:0] act_addr;
    logic signed [data_width-1:0] weight_data;
    logic [weight_addr_width-1:0] weight_addr;
    logic signed [data_width-1:0] act_bank_data;
    logic [bank_addr_width-1:0] act_bank_addr;
    logic [num_act_banks-1:0] act_bank_en;
    logic [num_act_banks-1:0] act_bank_we;
    logic signed [data_width-1:0] weight_bank_data;
    logic [bank_addr_width-1:0] weight_bank_addr;
    logic [num_weight_banks-1:0] weight_bank_en;
    logic [num_weight_banks-1:0] weight_bank_we;

    integer seed;
    int act_errors;
    int weight_errors;
    int done_errors;
    bit timed_out;

    // reference model state for the current layer
    layer_geom_pkg::layer_geom_t geom;
    int pad_w;
    int act_total;
    int weight_total;
    logic signed [data_width-1:0] act_bytes [0:1023];
    logic signed [data_width-1:0] weight_bytes [0:511];

    row_mem_loader i_dut (
        .clk(clk), .resetn(resetn), .start(start), .done(done),
        .oc(oc), .img_h(img_h), .img_w(img_w), .k(k), .stride(stride),
        .act_data(act_data), .act_addr(act_addr),
        .weight_data(weight_data), .weight_addr(weight_addr),
        .act_bank_data(act_bank_data), .act_bank_addr(act_bank_addr),
        .act_bank_en(act_bank_en), .act_bank_we(act_bank_we),
        .weight_bank_data(weight_bank_data), .weight_bank_addr(weight_bank_addr),
        .weight_bank_en(weight_bank_en), .weight_bank_we(weight_bank_we)
    );

    always #10 clk = ~clk;

    function automatic int random_in_range(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    // --------------------
    // compare tasks
    // --------------------

    task automatic check_act(
        input logic signed [data_width-1:0] got_data,
        input logic signed [data_width-1:0] exp_data,
        input logic [bank_addr_width-1:0] got_addr,
        input logic [bank_addr_width-1:0] exp_addr,
        input logic [num_act_banks-1:0] got_en,
        input logic [num_act_banks-1:0] got_we,
        input logic [num_act_banks-1:0] exp_en
    );
        if (got_data !== exp_data || got_addr !== exp_addr || got_en !== exp_en
                || got_we !== exp_en) begin
            $display("FAIL act_bank_data/addr/en/we at %0t: got %h %h %h %h expected %h %h %h",
                     $time, got_data, got_addr, got_en, got_we, exp_data, exp_addr, exp_en);
            act_errors++;
        end
    endtask

    task automatic check_weight(
        input logic signed [data_width-1:0] got_data,
        input logic signed [data_width-1:0] exp_data,
        input logic [bank_addr_width-1:0] got_addr,
        input logic [bank_addr_width-1:0] exp_addr,
        input logic [num_weight_banks-1:0] got_en,
        input logic [num_weight_banks-1:0] got_we,
        input logic [num_weight_banks-1:0] exp_en
    );
        if (got_data !== exp_data || got_addr !== exp_addr || got_en !== exp_en
                || got_we !== exp_en) begin
            $display("FAIL weight_bank_data/addr/en/we at %0t: got %h %h %h %h expected %h %h %h",
                     $time, got_data, got_addr, got_en, got_we, exp_data, exp_addr, exp_en);
            weight_errors++;
        end
    endtask

    task automatic check_done(input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL done at %0t: got %h expected %h", $time, got, exp);
            done_errors++;
        end
    endtask

    // --------------------
    // model and stimulus
    // --------------------

    task automatic draw_layer();
        int k_val;
        int stride_val;
        int max_h;
        int pad_h;
        k_val = random_in_range(1, 3);
        stride_val = random_in_range(1, 2);
        // padded height must fit the 32 activation banks
        max_h = (32 - k_val) / stride_val + 1;
        if (max_h > 12) begin
            max_h = 12;
        end
        geom.k = layer_geom_pkg::k_width'(k_val);
        geom.stride = layer_geom_pkg::stride_width'(stride_val);
        geom.img_h = layer_geom_pkg::img_width'(random_in_range(1, max_h));
        geom.img_w = layer_geom_pkg::img_width'(random_in_range(1, 12));
        geom.oc = layer_geom_pkg::oc_width'(random_in_range(1, 40));
        pad_w = (int'(geom.img_w) - 1) * stride_val + k_val;
        pad_h = (int'(geom.img_h) - 1) * stride_val + k_val;
        act_total = pad_h * pad_w;
        weight_total = k_val * k_val * int'(geom.oc);
        for (int a = 0; a < act_total; a++) begin
            act_bytes[a] = data_width'($random(seed));
        end
        for (int w = 0; w < weight_total; w++) begin
            weight_bytes[w] = data_width'($random(seed));
        end
    endtask

    // drive item i of both streams with addresses held at the totals once used up
    task automatic drive_item(input int i);
        start = (i == 0);
        act_addr = act_addr_width'((i < act_total) ? i : act_total);
        weight_addr = weight_addr_width'((i < weight_total) ? i : weight_total);
        act_data = (i < act_total) ? act_bytes[i] : data_width'($random(seed));
        weight_data = (i < weight_total) ? weight_bytes[i] : data_width'($random(seed));
        if (i == 0) begin
            {oc, img_h, img_w, k, stride} = geom;
        end else begin
            // geometry moves during the load and must not matter
            {oc, img_h, img_w, k, stride} = 26'($random(seed));
        end
    endtask

    // j is the stream index due at the outputs now and is negative when none is due
    task automatic check_outputs(input int j);
        logic signed [data_width-1:0] exp_act_data;
        logic [bank_addr_width-1:0] exp_act_addr;
        logic [num_act_banks-1:0] exp_act_en;
        logic signed [data_width-1:0] exp_w_data;
        logic [bank_addr_width-1:0] exp_w_addr;
        logic [num_weight_banks-1:0] exp_w_en;
        int kv;
        kv = int'(geom.k);
        exp_act_data = '0;
        exp_act_addr = '0;
        exp_act_en = '0;
        exp_w_data = '0;
        exp_w_addr = '0;
        exp_w_en = '0;
        if (j >= 0 && j < act_total) begin
            exp_act_data = act_bytes[j];
            exp_act_addr = bank_addr_width'(j % pad_w);
            exp_act_en = num_act_banks'(1) << (j / pad_w);
        end
        if (j >= 0 && j < weight_total) begin
            exp_w_data = weight_bytes[j];
            exp_w_addr = bank_addr_width'(j % kv + kv * (j / (kv * kv)));
            exp_w_en = num_weight_banks'(1) << ((j / kv) % kv);
        end
        check_act(act_bank_data, exp_act_data, act_bank_addr, exp_act_addr,
                  act_bank_en, act_bank_we, exp_act_en);
        check_weight(weight_bank_data, exp_w_data, weight_bank_addr, exp_w_addr,
                     weight_bank_en, weight_bank_we, exp_w_en);
    endtask

    task automatic run_layer(input int layer);
        int end_cycle;
        int limit;
        int i;
        bit seen_done;
        draw_layer();
        // done shows in the cycle after both stage-one addresses pass their totals
        end_cycle = ((act_total > weight_total) ? act_total : weight_total) + 2;
        limit = end_cycle + 20;
        i = 0;
        seen_done = 1'b0;
        while (!seen_done && i < limit) begin
            @(negedge clk);
            check_outputs(i - 2);
            check_done(done, i == end_cycle);
            seen_done = done;
            drive_item(i);
            i++;
        end
        if (!seen_done) begin
            $display("layer %0d: done never came within %0d cycles", layer, limit);
            done_errors++;
            timed_out = 1'b1;
        end
    endtask

    initial begin
        seed = 37;
        act_errors = 0;
        weight_errors = 0;
        done_errors = 0;
        timed_out = 1'b0;
        geom = '0;
        pad_w = 1;
        act_total = 0;
        weight_total = 0;
        clk = 1'b0;
        resetn = 1'b0;
        start = 1'b0;
        {oc, img_h, img_w, k, stride} = '0;
        act_data = '0;
        act_addr = '0;
        weight_data = '0;
        weight_addr = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        // quiet outputs before the first start
        repeat (3) begin
            @(negedge clk);
            check_outputs(-1);
            check_done(done, 1'b0);
        end

        for (int layer = 0; layer < num_layers; layer++) begin
            if (!timed_out) begin
                run_layer(layer);
            end
        end

        // stream addresses below the totals while idle must not write
        if (!timed_out) begin
            repeat (3) begin
                @(negedge clk);
                check_outputs(-1);
                check_done(done, 1'b0);
                act_addr = '0;
                weight_addr = '0;
                act_data = data_width'($random(seed));
                weight_data = data_width'($random(seed));
            end
        end

        $display("errors: act %0d, weight %0d, done %0d", act_errors, weight_errors,
                 done_errors);
        if (act_errors + weight_errors + done_errors == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== design/act_row_scatter.sv ====
module act_row_scatter #(
    parameter int data_width = row_mem_pkg::def_data_width,
    parameter int num_act_banks = row_mem_pkg::def_num_act_banks,
    parameter int act_addr_width = row_mem_pkg::def_act_addr_width,
    parameter int bank_addr_width = row_mem_pkg::def_bank_addr_width
) (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         loading,
    input  logic signed [data_width-1:0] act_data,
    input  logic [act_addr_width-1:0]    act_addr,
    layer_cfg_if.scatter                 cfg,
    output logic                         act_end,
    output logic signed [data_width-1:0] act_bank_data,
    output logic [bank_addr_width-1:0]   act_bank_addr,
    output logic [num_act_banks-1:0]     act_bank_en,
    output logic [num_act_banks-1:0]     act_bank_we
);

    localparam int bank_sel_width = $clog2(num_act_banks);

    logic signed [data_width-1:0] data_q;
    logic [act_addr_width-1:0] addr_q;
    logic [bank_addr_width-1:0] col_cnt;
    logic [bank_sel_width-1:0] bank_cnt;
    logic [num_act_banks-1:0] bank_onehot;
    logic item_valid;
    logic col_wrap;

    // --------------------
    // stage one
    // --------------------

    always_ff @(posedge clk) begin
        data_q <= act_data;
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            addr_q <= '0;
        end else begin
            addr_q <= act_addr;
        end
    end

    assign act_end = (addr_q >= cfg.act_total);
    assign item_valid = loading && !act_end;

    // column runs across one padded row, then the next bank takes over
    assign col_wrap = (col_cnt == cfg.act_row_len - bank_addr_width'(1));

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            col_cnt <= '0;
            bank_cnt <= '0;
        end else if (!loading) begin
            col_cnt <= '0;
            bank_cnt <= '0;
        end else if (item_valid) begin
            if (col_wrap) begin
                col_cnt <= '0;
                bank_cnt <= bank_cnt + bank_sel_width'(1);
            end else begin
                col_cnt <= col_cnt + bank_addr_width'(1);
            end
        end
    end

    // --------------------
    // bank write stage
    // --------------------

    assign bank_onehot = num_act_banks'(1) << bank_cnt;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            act_bank_data <= '0;
            act_bank_addr <= '0;
            act_bank_en <= '0;
            act_bank_we <= '0;
        end else if (item_valid) begin
            act_bank_data <= data_q;
            act_bank_addr <= col_cnt;
            act_bank_en <= bank_onehot;
            act_bank_we <= bank_onehot;
        end else begin
            act_bank_data <= '0;
            act_bank_addr <= '0;
            act_bank_en <= '0;
            act_bank_we <= '0;
        end
    end

endmodule

// ==== design/layer_cfg_if.sv ====
interface layer_cfg_if #(
    parameter int act_addr_width = row_mem_pkg::def_act_addr_width,
    parameter int weight_addr_width = row_mem_pkg::def_weight_addr_width,
    parameter int bank_addr_width = row_mem_pkg::def_bank_addr_width
);

    // geometry captured at launch
    layer_geom_pkg::layer_geom_t geom;

    // padded input width, length of one activation row
    logic [bank_addr_width-1:0] act_row_len;

    // item counts of the two streams
    logic [act_addr_width-1:0] act_total;
    logic [weight_addr_width-1:0] weight_total;

    modport cfg (
        output geom,
        output act_row_len,
        output act_total,
        output weight_total
    );

    modport scatter (
        input geom,
        input act_row_len,
        input act_total,
        input weight_total
    );

endinterface

// ==== design/layer_cfg_regs.sv ====
module layer_cfg_regs #(
    parameter int act_addr_width = row_mem_pkg::def_act_addr_width,
    parameter int weight_addr_width = row_mem_pkg::def_weight_addr_width,
    parameter int bank_addr_width = row_mem_pkg::def_bank_addr_width
) (
    input  logic                                    clk,
    input  logic                                    resetn,
    input  logic                                    launch,
    input  logic [layer_geom_pkg::oc_width-1:0]     oc,
    input  logic [layer_geom_pkg::img_width-1:0]    img_h,
    input  logic [layer_geom_pkg::img_width-1:0]    img_w,
    input  logic [layer_geom_pkg::k_width-1:0]      k,
    input  logic [layer_geom_pkg::stride_width-1:0] stride,
    layer_cfg_if.cfg                                cfg
);

    localparam logic [act_addr_width-1:0] unit = act_addr_width'(1);

    // fields widened to the activation address width before the math
    logic [act_addr_width-1:0] oc_ext;
    logic [act_addr_width-1:0] img_h_ext;
    logic [act_addr_width-1:0] img_w_ext;
    logic [act_addr_width-1:0] k_ext;
    logic [act_addr_width-1:0] stride_ext;
    logic [act_addr_width-1:0] pad_h;
    logic [act_addr_width-1:0] pad_w;
    logic [act_addr_width-1:0] kk_oc;

    // geometry is held for the whole load, inputs may move meanwhile
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            cfg.geom <= '0;
        end else if (launch) begin
            cfg.geom <= '{oc: oc, img_h: img_h, img_w: img_w, k: k, stride: stride};
        end
    end

    assign oc_ext = act_addr_width'(cfg.geom.oc);
    assign img_h_ext = act_addr_width'(cfg.geom.img_h);
    assign img_w_ext = act_addr_width'(cfg.geom.img_w);
    assign k_ext = act_addr_width'(cfg.geom.k);
    assign stride_ext = act_addr_width'(cfg.geom.stride);

    // --------------------
    // derived sizes
    // --------------------

    // padded input side is (out - 1) * stride + k
    assign pad_h = (img_h_ext - unit) * stride_ext + k_ext;
    assign pad_w = (img_w_ext - unit) * stride_ext + k_ext;

    // k * k taps for each output channel
    assign kk_oc = k_ext * k_ext * oc_ext;

    assign cfg.act_row_len = bank_addr_width'(pad_w);
    assign cfg.act_total = pad_h * pad_w;
    assign cfg.weight_total = weight_addr_width'(kk_oc);

endmodule

// ==== design/layer_geom_pkg.sv ====
package layer_geom_pkg;

    // --------------------
    // field widths
    // --------------------

    // output channels per layer
    localparam int oc_width = 8;

    // output image height and width
    localparam int img_width = 6;

    // kernel size and stride
    localparam int k_width = 3;
    localparam int stride_width = 3;

    // --------------------
    // layer geometry
    // --------------------

    // one layer as given on start, 26 bits in all
    typedef struct packed {
        logic [oc_width-1:0]     oc;
        logic [img_width-1:0]    img_h;
        logic [img_width-1:0]    img_w;
        logic [k_width-1:0]      k;
        logic [stride_width-1:0] stride;
    } layer_geom_t;

endpackage

// ==== design/load_ctrl.sv ====
module load_ctrl (
    input  logic clk,
    input  logic resetn,
    input  logic start,
    input  logic act_end,
    input  logic weight_end,
    output logic launch,
    output logic loading,
    output logic done
);

    row_mem_pkg::load_state_e state;
    row_mem_pkg::load_state_e state_next;

    // --------------------
    // state register
    // --------------------

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= row_mem_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    // --------------------
    // next state
    // --------------------

    always_comb begin
        state_next = state;
        case (state)
            row_mem_pkg::st_idle: begin
                if (start) begin
                    state_next = row_mem_pkg::st_load;
                end
            end
            // both stage-one addresses past their totals
            row_mem_pkg::st_load: begin
                if (act_end && weight_end) begin
                    state_next = row_mem_pkg::st_done;
                end
            end
            row_mem_pkg::st_done: begin
                state_next = row_mem_pkg::st_idle;
            end
            default: begin
                state_next = row_mem_pkg::st_idle;
            end
        endcase
    end

    // launch lands in the same cycle as start and stream address 0
    assign launch = (state == row_mem_pkg::st_idle) && start;
    assign loading = (state == row_mem_pkg::st_load);
    assign done = (state == row_mem_pkg::st_done);

endmodule

// ==== design/row_mem_loader.sv ====
module row_mem_loader #(
    parameter int data_width = row_mem_pkg::def_data_width,
    parameter int num_act_banks = row_mem_pkg::def_num_act_banks,
    parameter int num_weight_banks = row_mem_pkg::def_num_weight_banks,
    parameter int act_addr_width = row_mem_pkg::def_act_addr_width,
    parameter int weight_addr_width = row_mem_pkg::def_weight_addr_width,
    parameter int bank_addr_width = row_mem_pkg::def_bank_addr_width
) (
    input  logic                                    clk,
    input  logic                                    resetn,
    input  logic                                    start,
    output logic                                    done,
    input  logic [layer_geom_pkg::oc_width-1:0]     oc,
    input  logic [layer_geom_pkg::img_width-1:0]    img_h,
    input  logic [layer_geom_pkg::img_width-1:0]    img_w,
    input  logic [layer_geom_pkg::k_width-1:0]      k,
    input  logic [layer_geom_pkg::stride_width-1:0] stride,
    input  logic signed [data_width-1:0]            act_data,
    input  logic [act_addr_width-1:0]               act_addr,
    input  logic signed [data_width-1:0]            weight_data,
    input  logic [weight_addr_width-1:0]            weight_addr,
    output logic signed [data_width-1:0]            act_bank_data,
    output logic [bank_addr_width-1:0]              act_bank_addr,
    output logic [num_act_banks-1:0]                act_bank_en,
    output logic [num_act_banks-1:0]                act_bank_we,
    output logic signed [data_width-1:0]            weight_bank_data,
    output logic [bank_addr_width-1:0]              weight_bank_addr,
    output logic [num_weight_banks-1:0]             weight_bank_en,
    output logic [num_weight_banks-1:0]             weight_bank_we
);

    logic launch;
    logic loading;
    logic act_end;
    logic weight_end;

    // captured geometry and totals, shared by both scatter units
    layer_cfg_if #(
        .act_addr_width(act_addr_width),
        .weight_addr_width(weight_addr_width),
        .bank_addr_width(bank_addr_width)
    ) cfg_bus ();

    load_ctrl i_load_ctrl (
        .clk(clk),
        .resetn(resetn),
        .start(start),
        .act_end(act_end),
        .weight_end(weight_end),
        .launch(launch),
        .loading(loading),
        .done(done)
    );

    layer_cfg_regs #(
        .act_addr_width(act_addr_width),
        .weight_addr_width(weight_addr_width),
        .bank_addr_width(bank_addr_width)
    ) i_layer_cfg_regs (
        .clk(clk),
        .resetn(resetn),
        .launch(launch),
        .oc(oc),
        .img_h(img_h),
        .img_w(img_w),
        .k(k),
        .stride(stride),
        .cfg(cfg_bus.cfg)
    );

    // --------------------
    // stream scatter
    // --------------------

    act_row_scatter #(
        .data_width(data_width),
        .num_act_banks(num_act_banks),
        .act_addr_width(act_addr_width),
        .bank_addr_width(bank_addr_width)
    ) i_act_row_scatter (
        .clk(clk),
        .resetn(resetn),
        .loading(loading),
        .act_data(act_data),
        .act_addr(act_addr),
        .cfg(cfg_bus.scatter),
        .act_end(act_end),
        .act_bank_data(act_bank_data),
        .act_bank_addr(act_bank_addr),
        .act_bank_en(act_bank_en),
        .act_bank_we(act_bank_we)
    );

    weight_row_scatter #(
        .data_width(data_width),
        .num_weight_banks(num_weight_banks),
        .weight_addr_width(weight_addr_width),
        .bank_addr_width(bank_addr_width)
    ) i_weight_row_scatter (
        .clk(clk),
        .resetn(resetn),
        .loading(loading),
        .weight_data(weight_data),
        .weight_addr(weight_addr),
        .cfg(cfg_bus.scatter),
        .weight_end(weight_end),
        .weight_bank_data(weight_bank_data),
        .weight_bank_addr(weight_bank_addr),
        .weight_bank_en(weight_bank_en),
        .weight_bank_we(weight_bank_we)
    );

endmodule

// ==== design/row_mem_pkg.sv ====
package row_mem_pkg;

    // --------------------
    // loader states
    // --------------------

    // idle until start, load while the streams run, one cycle of done
    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_done
    } load_state_e;

    // --------------------
    // default sizes
    // --------------------

    // byte width of activations and weights
    localparam int def_data_width = 8;

    // one activation bank per padded input row
    localparam int def_num_act_banks = 32;

    // one weight bank per kernel row, kernel at most 3
    localparam int def_num_weight_banks = 3;

    // flat stream address widths
    localparam int def_act_addr_width = 13;
    localparam int def_weight_addr_width = 9;

    // address width inside one bank
    localparam int def_bank_addr_width = 7;

endpackage

// ==== design/weight_row_scatter.sv ====
module weight_row_scatter #(
    parameter int data_width = row_mem_pkg::def_data_width,
    parameter int num_weight_banks = row_mem_pkg::def_num_weight_banks,
    parameter int weight_addr_width = row_mem_pkg::def_weight_addr_width,
    parameter int bank_addr_width = row_mem_pkg::def_bank_addr_width
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          loading,
    input  logic signed [data_width-1:0]  weight_data,
    input  logic [weight_addr_width-1:0]  weight_addr,
    layer_cfg_if.scatter                  cfg,
    output logic                          weight_end,
    output logic signed [data_width-1:0]  weight_bank_data,
    output logic [bank_addr_width-1:0]    weight_bank_addr,
    output logic [num_weight_banks-1:0]   weight_bank_en,
    output logic [num_weight_banks-1:0]   weight_bank_we
);

    localparam int bank_sel_width = $clog2(num_weight_banks);

    logic signed [data_width-1:0] data_q;
    logic [weight_addr_width-1:0] addr_q;
    logic [layer_geom_pkg::k_width-1:0] last_k;
    logic [layer_geom_pkg::k_width-1:0] tap_cnt;
    logic [bank_sel_width-1:0] row_cnt;
    logic [layer_geom_pkg::oc_width-1:0] chan_cnt;
    logic [bank_addr_width-1:0] bank_addr_next;
    logic [num_weight_banks-1:0] bank_onehot;
    logic item_valid;
    logic tap_wrap;
    logic row_wrap;

    // --------------------
    // stage one
    // --------------------

    always_ff @(posedge clk) begin
        data_q <= weight_data;
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            addr_q <= '0;
        end else begin
            addr_q <= weight_addr;
        end
    end

    assign weight_end = (addr_q >= cfg.weight_total);
    assign item_valid = loading && !weight_end;

    assign last_k = cfg.geom.k - layer_geom_pkg::k_width'(1);
    assign tap_wrap = (tap_cnt == last_k);
    assign row_wrap = (row_cnt == bank_sel_width'(last_k));

    // tap within a kernel row, kernel row picks the bank, channel every k*k
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            tap_cnt <= '0;
            row_cnt <= '0;
            chan_cnt <= '0;
        end else if (!loading) begin
            tap_cnt <= '0;
            row_cnt <= '0;
            chan_cnt <= '0;
        end else if (item_valid) begin
            if (tap_wrap) begin
                tap_cnt <= '0;
                if (row_wrap) begin
                    row_cnt <= '0;
                    chan_cnt <= chan_cnt + layer_geom_pkg::oc_width'(1);
                end else begin
                    row_cnt <= row_cnt + bank_sel_width'(1);
                end
            end else begin
                tap_cnt <= tap_cnt + layer_geom_pkg::k_width'(1);
            end
        end
    end

    // --------------------
    // bank write stage
    // --------------------

    // each bank keeps one kernel row per channel, k entries apart
    assign bank_addr_next = bank_addr_width'(tap_cnt)
                          + bank_addr_width'(cfg.geom.k) * bank_addr_width'(chan_cnt);
    assign bank_onehot = num_weight_banks'(1) << row_cnt;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            weight_bank_data <= '0;
            weight_bank_addr <= '0;
            weight_bank_en <= '0;
            weight_bank_we <= '0;
        end else if (item_valid) begin
            weight_bank_data <= data_q;
            weight_bank_addr <= bank_addr_next;
            weight_bank_en <= bank_onehot;
            weight_bank_we <= bank_onehot;
        end else begin
            weight_bank_data <= '0;
            weight_bank_addr <= '0;
            weight_bank_en <= '0;
            weight_bank_we <= '0;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module row_mem_loader_tb -f sources.f -o row_mem_loader_sim \
    && ./obj_dir/row_mem_loader_sim | tee /dev/stderr | grep -q "All tests passed" \
    && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }

// ==== sources.f ====
design/layer_geom_pkg.sv
design/row_mem_pkg.sv
design/layer_cfg_if.sv
design/layer_cfg_regs.sv
design/load_ctrl.sv
design/act_row_scatter.sv
design/weight_row_scatter.sv
design/row_mem_loader.sv
bench/row_mem_loader_props.sv
bench/row_mem_loader_tb.sv
